//--- reuleaux_pkg.sv
package reuleaux_pkg;

  // Frame buffer geometry
  localparam int SCREEN_W = 160;
  localparam int SCREEN_H = 120;

  localparam int X_BITS      = 8;
  localparam int Y_BITS      = 7;
  localparam int COLOUR_BITS = 3;

  // Q0.11 constants, sqrt(3)/6 and sqrt(3)/3
  localparam int FRAC_BITS = 11;
  localparam logic [FRAC_BITS-1:0] SQRT3_6_Q = 11'd591;
  localparam logic [FRAC_BITS-1:0] SQRT3_3_Q = 11'd1182;

  localparam logic [COLOUR_BITS-1:0] FILL_COLOUR = 3'd0;

  // Signed working coordinate, wide enough for off-screen corners
  localparam int COORD_BITS = 10;

  typedef struct packed {
    logic [X_BITS-1:0]      x;
    logic [Y_BITS-1:0]      y;
    logic [COLOUR_BITS-1:0] colour;
  } pixel_t;

  typedef struct packed {
    logic signed [COORD_BITS-1:0] x;
    logic signed [COORD_BITS-1:0] y;
  } corner_t;

endpackage

//--- screen_fill.sv
module screen_fill (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  output reuleaux_pkg::pixel_t pixel,
  output logic                 plot,
  output logic                 done
);

  logic [reuleaux_pkg::X_BITS-1:0] x;
  logic [reuleaux_pkg::Y_BITS-1:0] y;
  logic                            busy;
  logic                            row_end;
  logic                            last;

  assign row_end = (x == reuleaux_pkg::SCREEN_W - 1);
  assign last    = row_end && (y == reuleaux_pkg::SCREEN_H - 1);

  // Raster sweep, x fastest
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      busy <= 1'b0;
      done <= 1'b0;
      x    <= '0;
      y    <= '0;
    end
    else
    begin
      done <= 1'b0;
      if (start)
      begin
        busy <= 1'b1;
        x    <= '0;
        y    <= '0;
      end
      else if (busy)
      begin
        if (row_end)
        begin
          x <= '0;
          y <= y + 1'b1;
        end
        else
        begin
          x <= x + 1'b1;
        end
        if (last)
        begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  assign pixel = '{x: x, y: y, colour: reuleaux_pkg::FILL_COLOUR};
  assign plot  = busy;

  a_fill_on_screen: assert property (@(posedge clk) disable iff (!rst_n)
    plot |-> (pixel.x < reuleaux_pkg::SCREEN_W && pixel.y < reuleaux_pkg::SCREEN_H));

endmodule

//--- arc_tracer.sv
module arc_tracer (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 start,
  input  reuleaux_pkg::corner_t                centre,
  input  reuleaux_pkg::corner_t                far_a,
  input  reuleaux_pkg::corner_t                far_b,
  input  logic [reuleaux_pkg::X_BITS-1:0]      radius,
  input  logic [reuleaux_pkg::COLOUR_BITS-1:0] colour,
  output reuleaux_pkg::pixel_t                 pixel,
  output logic                                 plot,
  output logic                                 done
);

  reuleaux_pkg::corner_t                cen_r;
  reuleaux_pkg::corner_t                far_a_r;
  reuleaux_pkg::corner_t                far_b_r;
  logic [reuleaux_pkg::COLOUR_BITS-1:0] colour_r;
  logic                                 busy;
  logic [2:0]                           oct;
  logic                                 finish;

  // Octant walk state, one bit wider than a coordinate
  logic signed [reuleaux_pkg::COORD_BITS:0] ox;
  logic signed [reuleaux_pkg::COORD_BITS:0] oy;
  logic signed [reuleaux_pkg::COORD_BITS:0] crit;
  logic signed [reuleaux_pkg::COORD_BITS:0] ox_next;
  logic signed [reuleaux_pkg::COORD_BITS:0] oy_next;
  logic signed [reuleaux_pkg::COORD_BITS:0] crit_next;
  logic signed [reuleaux_pkg::COORD_BITS:0] rad_w;
  logic signed [reuleaux_pkg::COORD_BITS:0] dx;
  logic signed [reuleaux_pkg::COORD_BITS:0] dy;
  logic signed [reuleaux_pkg::COORD_BITS:0] cen_x;
  logic signed [reuleaux_pkg::COORD_BITS:0] cen_y;
  logic signed [reuleaux_pkg::COORD_BITS:0] px;
  logic signed [reuleaux_pkg::COORD_BITS:0] py;
  logic signed [reuleaux_pkg::COORD_BITS-1:0] lo_x;
  logic signed [reuleaux_pkg::COORD_BITS-1:0] hi_x;
  logic is_top;
  logic in_span;
  logic in_half;
  logic on_screen;

  assign rad_w = {{(reuleaux_pkg::COORD_BITS + 1 - reuleaux_pkg::X_BITS){1'b0}}, radius};

  // Midpoint step, taken after the eighth point of each octant position
  always_comb
  begin
    oy_next = oy + 1;
    if (crit <= 0)
    begin
      ox_next   = ox;
      crit_next = crit + (oy_next <<< 1) + 1;
    end
    else
    begin
      ox_next   = ox - 1;
      crit_next = crit + ((oy_next - ox_next) <<< 1) + 1;
    end
  end

  assign finish = (oy_next > ox_next);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      busy <= 1'b0;
      done <= 1'b0;
      oct  <= '0;
    end
    else
    begin
      done <= 1'b0;
      if (start)
      begin
        busy <= 1'b1;
        oct  <= '0;
      end
      else if (busy)
      begin
        oct <= oct + 1'b1;
        if (oct == 3'd7 && finish)
        begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      cen_r    <= centre;
      far_a_r  <= far_a;
      far_b_r  <= far_b;
      colour_r <= colour;
      ox       <= rad_w;
      oy       <= '0;
      crit     <= 1 - rad_w;
    end
    else if (busy && oct == 3'd7)
    begin
      ox   <= ox_next;
      oy   <= oy_next;
      crit <= crit_next;
    end
  end

  // Eight symmetric points
  always_comb
  begin
    case (oct)
      3'd0:
      begin
        dx = ox;
        dy = oy;
      end
      3'd1:
      begin
        dx = oy;
        dy = ox;
      end
      3'd2:
      begin
        dx = -oy;
        dy = ox;
      end
      3'd3:
      begin
        dx = -ox;
        dy = oy;
      end
      3'd4:
      begin
        dx = -ox;
        dy = -oy;
      end
      3'd5:
      begin
        dx = -oy;
        dy = -ox;
      end
      3'd6:
      begin
        dx = oy;
        dy = -ox;
      end
      default:
      begin
        dx = ox;
        dy = -oy;
      end
    endcase
  end

  assign cen_x = {cen_r.x[reuleaux_pkg::COORD_BITS-1], cen_r.x};
  assign cen_y = {cen_r.y[reuleaux_pkg::COORD_BITS-1], cen_r.y};
  assign px    = cen_x + dx;
  assign py    = cen_y + dy;

  // Top corner sits above both others, so its arc is the lower edge
  assign is_top    = (cen_r.y < far_a_r.y);
  assign lo_x      = (far_a_r.x < far_b_r.x) ? far_a_r.x : far_b_r.x;
  assign hi_x      = (far_a_r.x < far_b_r.x) ? far_b_r.x : far_a_r.x;
  assign in_span   = (px >= lo_x) && (px <= hi_x);
  assign in_half   = is_top ? (py >= cen_y) : (py <= cen_y);
  assign on_screen = (px >= 0) && (px < reuleaux_pkg::SCREEN_W) &&
                     (py >= 0) && (py < reuleaux_pkg::SCREEN_H);

  assign plot = busy && in_span && in_half && on_screen;

  always_comb
  begin
    pixel.x      = px[reuleaux_pkg::X_BITS-1:0];
    pixel.y      = py[reuleaux_pkg::Y_BITS-1:0];
    pixel.colour = colour_r;
  end

  a_no_plot_with_done: assert property (@(posedge clk) disable iff (!rst_n)
    !(done && plot));

  // Walk never runs past the 45 degree line while plotting
  a_plot_in_octant: assert property (@(posedge clk) disable iff (!rst_n)
    plot |-> (oy <= ox));

endmodule

//--- corner_calc.sv
module corner_calc (
  input  logic [reuleaux_pkg::X_BITS-1:0] centre_x,
  input  logic [reuleaux_pkg::Y_BITS-1:0] centre_y,
  input  logic [reuleaux_pkg::X_BITS-1:0] diameter,
  output reuleaux_pkg::corner_t           right,
  output reuleaux_pkg::corner_t           left,
  output reuleaux_pkg::corner_t           top
);

  logic [reuleaux_pkg::X_BITS+reuleaux_pkg::FRAC_BITS-1:0] prod_b;
  logic [reuleaux_pkg::X_BITS+reuleaux_pkg::FRAC_BITS-1:0] prod_t;
  logic signed [reuleaux_pkg::COORD_BITS-1:0]              cx;
  logic signed [reuleaux_pkg::COORD_BITS-1:0]              cy;
  logic signed [reuleaux_pkg::COORD_BITS-1:0]              h;
  logic signed [reuleaux_pkg::COORD_BITS-1:0]              b;
  logic signed [reuleaux_pkg::COORD_BITS-1:0]              t;

  assign prod_b = diameter * reuleaux_pkg::SQRT3_6_Q;
  assign prod_t = diameter * reuleaux_pkg::SQRT3_3_Q;

  assign cx = {{(reuleaux_pkg::COORD_BITS - reuleaux_pkg::X_BITS){1'b0}}, centre_x};
  assign cy = {{(reuleaux_pkg::COORD_BITS - reuleaux_pkg::Y_BITS){1'b0}}, centre_y};
  assign h  = {{(reuleaux_pkg::COORD_BITS - reuleaux_pkg::X_BITS + 1){1'b0}},
               diameter[reuleaux_pkg::X_BITS-1:1]};

  // Integer part of the Q.11 products, fraction dropped
  assign b = {{(reuleaux_pkg::COORD_BITS - reuleaux_pkg::X_BITS){1'b0}},
              prod_b[reuleaux_pkg::X_BITS+reuleaux_pkg::FRAC_BITS-1:reuleaux_pkg::FRAC_BITS]};
  assign t = {{(reuleaux_pkg::COORD_BITS - reuleaux_pkg::X_BITS){1'b0}},
              prod_t[reuleaux_pkg::X_BITS+reuleaux_pkg::FRAC_BITS-1:reuleaux_pkg::FRAC_BITS]};

  assign right = '{x: cx + h, y: cy + b};
  assign left  = '{x: cx - h, y: cy + b};
  assign top   = '{x: cx, y: cy - t};

endmodule

//--- reuleaux_seq.sv
module reuleaux_seq (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  reuleaux_pkg::corner_t right,
  input  reuleaux_pkg::corner_t left,
  input  reuleaux_pkg::corner_t top,
  input  reuleaux_pkg::pixel_t  fill_pixel,
  input  logic                  fill_plot,
  input  logic                  fill_done,
  input  reuleaux_pkg::pixel_t  arc_pixel,
  input  logic                  arc_plot,
  input  logic                  arc_done,
  output logic                  fill_start,
  output logic                  arc_start,
  output reuleaux_pkg::corner_t arc_centre,
  output reuleaux_pkg::corner_t arc_far_a,
  output reuleaux_pkg::corner_t arc_far_b,
  output reuleaux_pkg::pixel_t  pixel,
  output logic                  plot,
  output logic                  done
);

  typedef enum logic [2:0] {
    st_idle,
    st_fill,
    st_arc_right,
    st_arc_left,
    st_arc_top,
    st_finished
  } state_t;

  state_t state;

  // Engine starts pulse in the first cycle of their state
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state      <= st_idle;
      fill_start <= 1'b0;
      arc_start  <= 1'b0;
    end
    else
    begin
      fill_start <= 1'b0;
      arc_start  <= 1'b0;
      case (state)
        st_idle:
        begin
          if (start)
          begin
            state      <= st_fill;
            fill_start <= 1'b1;
          end
        end
        st_fill:
        begin
          if (fill_done)
          begin
            state     <= st_arc_right;
            arc_start <= 1'b1;
          end
        end
        st_arc_right:
        begin
          if (arc_done)
          begin
            state     <= st_arc_left;
            arc_start <= 1'b1;
          end
        end
        st_arc_left:
        begin
          if (arc_done)
          begin
            state     <= st_arc_top;
            arc_start <= 1'b1;
          end
        end
        st_arc_top:
        begin
          if (arc_done)
          begin
            state <= st_finished;
          end
        end
        st_finished:
        begin
          state <= st_finished;
        end
        default:
        begin
          state <= st_idle;
        end
      endcase
    end
  end

  // Arc centre and the two corners that bound it
  always_comb
  begin
    case (state)
      st_arc_left:
      begin
        arc_centre = left;
        arc_far_a  = top;
        arc_far_b  = right;
      end
      st_arc_top:
      begin
        arc_centre = top;
        arc_far_a  = left;
        arc_far_b  = right;
      end
      default:
      begin
        arc_centre = right;
        arc_far_a  = top;
        arc_far_b  = left;
      end
    endcase
  end

  always_comb
  begin
    case (state)
      st_fill:
      begin
        pixel = fill_pixel;
        plot  = fill_plot;
      end
      st_arc_right, st_arc_left, st_arc_top:
      begin
        pixel = arc_pixel;
        plot  = arc_plot;
      end
      default:
      begin
        pixel = '0;
        plot  = 1'b0;
      end
    endcase
  end

  assign done = (state == st_finished);

  // Both engines must be quiet once the drawing is done
  a_done_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> !(fill_plot || arc_plot));

endmodule

//--- reuleaux.sv
module reuleaux (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 start,
  input  logic [reuleaux_pkg::COLOUR_BITS-1:0] colour,
  input  logic [reuleaux_pkg::X_BITS-1:0]      centre_x,
  input  logic [reuleaux_pkg::Y_BITS-1:0]      centre_y,
  input  logic [reuleaux_pkg::X_BITS-1:0]      diameter,
  output reuleaux_pkg::pixel_t                 pixel,
  output logic                                 plot,
  output logic                                 done
);

  reuleaux_pkg::corner_t right;
  reuleaux_pkg::corner_t left;
  reuleaux_pkg::corner_t top;
  reuleaux_pkg::corner_t arc_centre;
  reuleaux_pkg::corner_t arc_far_a;
  reuleaux_pkg::corner_t arc_far_b;
  reuleaux_pkg::pixel_t  fill_pixel;
  reuleaux_pkg::pixel_t  arc_pixel;
  logic                  fill_start;
  logic                  fill_plot;
  logic                  fill_done;
  logic                  arc_start;
  logic                  arc_plot;
  logic                  arc_done;

  corner_calc corner_calc_i (
    .centre_x (centre_x),
    .centre_y (centre_y),
    .diameter (diameter),
    .right    (right),
    .left     (left),
    .top      (top)
  );

  screen_fill screen_fill_i (
    .clk   (clk),
    .rst_n (rst_n),
    .start (fill_start),
    .pixel (fill_pixel),
    .plot  (fill_plot),
    .done  (fill_done)
  );

  // Radius of each arc is the full diameter
  arc_tracer arc_tracer_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (arc_start),
    .centre (arc_centre),
    .far_a  (arc_far_a),
    .far_b  (arc_far_b),
    .radius (diameter),
    .colour (colour),
    .pixel  (arc_pixel),
    .plot   (arc_plot),
    .done   (arc_done)
  );

  reuleaux_seq reuleaux_seq_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .right      (right),
    .left       (left),
    .top        (top),
    .fill_pixel (fill_pixel),
    .fill_plot  (fill_plot),
    .fill_done  (fill_done),
    .arc_pixel  (arc_pixel),
    .arc_plot   (arc_plot),
    .arc_done   (arc_done),
    .fill_start (fill_start),
    .arc_start  (arc_start),
    .arc_centre (arc_centre),
    .arc_far_a  (arc_far_a),
    .arc_far_b  (arc_far_b),
    .pixel      (pixel),
    .plot       (plot),
    .done       (done)
  );

endmodule

//--- tb_reuleaux.sv
module tb_reuleaux;

  localparam int XB         = reuleaux_pkg::X_BITS;
  localparam int YB         = reuleaux_pkg::Y_BITS;
  localparam int CB         = reuleaux_pkg::COORD_BITS;
  localparam int FILL_TOTAL = reuleaux_pkg::SCREEN_W * reuleaux_pkg::SCREEN_H;
  localparam int N_ROWS     = 4;

  typedef struct packed {
    logic [reuleaux_pkg::X_BITS-1:0]      cx;
    logic [reuleaux_pkg::Y_BITS-1:0]      cy;
    logic [reuleaux_pkg::X_BITS-1:0]      d;
    logic [reuleaux_pkg::COLOUR_BITS-1:0] col;
  } row_t;

  // Centre x, centre y, diameter, colour
  localparam row_t ROWS [N_ROWS] = '{
    '{8'd80, 7'd60, 8'd80, 3'd2},
    '{8'd80, 7'd60, 8'd40, 3'd5},
    '{8'd20, 7'd20, 8'd60, 3'd7},
    '{8'd150, 7'd100, 8'd30, 3'd1}
  };

  logic                                 clk;
  logic                                 rst_n;
  logic                                 start;
  logic [reuleaux_pkg::COLOUR_BITS-1:0] colour;
  logic [reuleaux_pkg::X_BITS-1:0]      centre_x;
  logic [reuleaux_pkg::Y_BITS-1:0]      centre_y;
  logic [reuleaux_pkg::X_BITS-1:0]      diameter;
  reuleaux_pkg::pixel_t                 pixel;
  logic                                 plot;
  logic                                 done;

  logic [reuleaux_pkg::COLOUR_BITS-1:0] screen [reuleaux_pkg::SCREEN_W][reuleaux_pkg::SCREEN_H];
  int cor_x [3];
  int cor_y [3];
  int errors = 0;
  int checks = 0;

  reuleaux reuleaux_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .colour   (colour),
    .centre_x (centre_x),
    .centre_y (centre_y),
    .diameter (diameter),
    .pixel    (pixel),
    .plot     (plot),
    .done     (done)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Budget per row covers the fill, three arcs and slack, doubled
  initial
  begin
    int     max_d;
    longint limit;
    max_d = 0;
    for (int r = 0; r < N_ROWS; r++)
    begin
      if (int'(ROWS[r].d) > max_d)
        max_d = int'(ROWS[r].d);
    end
    limit = longint'(N_ROWS) * (FILL_TOTAL + 3 * 8 * max_d + 100) * 2 * 40;
    #(limit);
    $display("Timeout: the run did not finish within %0d time units", limit);
    $display("Checks failed");
    $finish;
  end

  function automatic reuleaux_pkg::corner_t make_corner(input int x, input int y);
    reuleaux_pkg::corner_t c;
    c.x = CB'(x);
    c.y = CB'(y);
    return c;
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic check_pixel(input string name, input reuleaux_pkg::pixel_t got,
                             input reuleaux_pkg::pixel_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_corner(input string name, input reuleaux_pkg::corner_t got,
                              input reuleaux_pkg::corner_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %s: got x=%h y=%h, expected x=%h y=%h",
               name, got.x, got.y, exp.x, exp.y);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // Arc k is centred on corner k; the other two corners bound its x span
  task automatic inspect_arc_pixel(input int k, input reuleaux_pkg::pixel_t p, input row_t row);
    reuleaux_pkg::pixel_t exp_px;
    int px;
    int py;
    int d2;
    int rad;
    int lo;
    int hi;
    exp_px        = p;
    exp_px.colour = row.col;
    check_pixel("pixel", p, exp_px);
    checks++;
    if (k > 2)
    begin
      report_error("Arc pixel plotted after the third arc had finished");
      return;
    end
    px  = int'(p.x);
    py  = int'(p.y);
    rad = int'(row.d);
    d2  = (px - cor_x[k]) * (px - cor_x[k]) + (py - cor_y[k]) * (py - cor_y[k]);
    lo  = (cor_x[(k + 1) % 3] < cor_x[(k + 2) % 3]) ? cor_x[(k + 1) % 3] : cor_x[(k + 2) % 3];
    hi  = (cor_x[(k + 1) % 3] < cor_x[(k + 2) % 3]) ? cor_x[(k + 2) % 3] : cor_x[(k + 1) % 3];
    if (px >= reuleaux_pkg::SCREEN_W || py >= reuleaux_pkg::SCREEN_H)
      report_error($sformatf("Arc %0d pixel (%0d,%0d) lies off screen", k, px, py));
    if (d2 < (rad - 1) * (rad - 1) || d2 > (rad + 1) * (rad + 1))
      report_error($sformatf("Arc %0d pixel (%0d,%0d) is not within one pixel of radius %0d",
                             k, px, py, rad));
    if (px < lo || px > hi)
      report_error($sformatf("Arc %0d pixel (%0d,%0d) is outside x span %0d..%0d",
                             k, px, py, lo, hi));
    if ((k == 2 && py < cor_y[k]) || (k != 2 && py > cor_y[k]))
      report_error($sformatf("Arc %0d pixel (%0d,%0d) is on the wrong side of y %0d",
                             k, px, py, cor_y[k]));
  endtask

  // Octant rounding can land one pixel off the exact corner
  task automatic scan_corners(input logic [reuleaux_pkg::COLOUR_BITS-1:0] col);
    bit found;
    for (int k = 0; k < 3; k++)
    begin
      found = 1'b0;
      if (cor_x[k] >= 0 && cor_x[k] < reuleaux_pkg::SCREEN_W &&
          cor_y[k] >= 0 && cor_y[k] < reuleaux_pkg::SCREEN_H)
      begin
        checks++;
        for (int x = cor_x[k] - 1; x <= cor_x[k] + 1; x++)
        begin
          for (int y = cor_y[k] - 1; y <= cor_y[k] + 1; y++)
          begin
            if (x >= 0 && x < reuleaux_pkg::SCREEN_W && y >= 0 && y < reuleaux_pkg::SCREEN_H)
            begin
              if (screen[x][y] == col)
                found = 1'b1;
            end
          end
        end
        if (!found)
          report_error($sformatf("Corner %0d at (%0d,%0d) was not drawn in the arc colour",
                                 k, cor_x[k], cor_y[k]));
      end
    end
  endtask

  task automatic run_row(input int r);
    row_t                 row;
    reuleaux_pkg::pixel_t exp_px;
    int                   err_start;
    int                   fill_count;
    int                   arc_count;
    int                   arc_idx;
    int                   h;
    int                   b;
    int                   t;
    row       = ROWS[r];
    err_start = errors;
    h = int'(row.d) >> 1;
    b = (int'(row.d) * int'(reuleaux_pkg::SQRT3_6_Q)) >> reuleaux_pkg::FRAC_BITS;
    t = (int'(row.d) * int'(reuleaux_pkg::SQRT3_3_Q)) >> reuleaux_pkg::FRAC_BITS;
    cor_x[0] = int'(row.cx) + h;
    cor_y[0] = int'(row.cy) + b;
    cor_x[1] = int'(row.cx) - h;
    cor_y[1] = int'(row.cy) + b;
    cor_x[2] = int'(row.cx);
    cor_y[2] = int'(row.cy) - t;
    for (int x = 0; x < reuleaux_pkg::SCREEN_W; x++)
    begin
      for (int y = 0; y < reuleaux_pkg::SCREEN_H; y++)
        screen[x][y] = '0;
    end

    @(posedge clk);
    #2;
    rst_n    = 1'b0;
    start    = 1'b0;
    centre_x = row.cx;
    centre_y = row.cy;
    diameter = row.d;
    colour   = row.col;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Quiet while idle
    repeat (5)
    begin
      @(negedge clk);
      check_flag("plot", plot, 1'b0);
      check_flag("done", done, 1'b0);
    end
    check_corner("right", reuleaux_i.right, make_corner(cor_x[0], cor_y[0]));
    check_corner("left", reuleaux_i.left, make_corner(cor_x[1], cor_y[1]));
    check_corner("top", reuleaux_i.top, make_corner(cor_x[2], cor_y[2]));

    @(posedge clk);
    #2;
    start = 1'b1;
    @(posedge clk);
    #2;
    start = 1'b0;

    fill_count = 0;
    arc_count  = 0;
    arc_idx    = 0;
    do
    begin
      @(negedge clk);
      if (plot)
      begin
        if (fill_count < FILL_TOTAL)
        begin
          exp_px.x      = XB'(fill_count % reuleaux_pkg::SCREEN_W);
          exp_px.y      = YB'(fill_count / reuleaux_pkg::SCREEN_W);
          exp_px.colour = reuleaux_pkg::FILL_COLOUR;
          check_pixel("pixel", pixel, exp_px);
          fill_count++;
        end
        else
        begin
          inspect_arc_pixel(arc_idx, pixel, row);
          arc_count++;
        end
        if (pixel.x < reuleaux_pkg::SCREEN_W && pixel.y < reuleaux_pkg::SCREEN_H)
          screen[pixel.x][pixel.y] = pixel.colour;
      end
      if (reuleaux_i.arc_done)
        arc_idx++;
    end
    while (!done);

    checks++;
    if (fill_count != FILL_TOTAL)
      report_error($sformatf("Fill plotted %0d pixels instead of %0d", fill_count, FILL_TOTAL));
    checks++;
    if (arc_idx != 3)
      report_error($sformatf("Done rose after %0d arcs instead of 3", arc_idx));
    scan_corners(row.col);

    // Start must be ignored once finished
    for (int i = 0; i < 50; i++)
    begin
      @(posedge clk);
      #2;
      start = (i == 10);
      @(negedge clk);
      check_flag("plot", plot, 1'b0);
      check_flag("done", done, 1'b1);
    end
    start = 1'b0;

    $display("Test %0d centre (%0d,%0d) diameter %0d colour %0d: %0d fill, %0d arc pixels, %0s",
             r, row.cx, row.cy, row.d, row.col, fill_count, arc_count,
             (errors == err_start) ? "ok" : "errors found");
  endtask

  initial
  begin
    rst_n    = 1'b0;
    start    = 1'b0;
    colour   = '0;
    centre_x = '0;
    centre_y = '0;
    diameter = '0;
    for (int r = 0; r < N_ROWS; r++)
      run_row(r);
    $display("Tests %0d, checks %0d, errors %0d", N_ROWS, checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

//--- sources.f
reuleaux_pkg.sv
screen_fill.sv
arc_tracer.sv
corner_calc.sv
reuleaux_seq.sv
reuleaux.sv
tb_reuleaux.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tb_reuleaux -o sim_reuleaux
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_reuleaux > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "All checks passed" sim.log; then
  exit 0
fi
exit 1
